// File: execUnit.f
hw/aluPkg.sv
hw/regFile.sv
hw/aluCore.sv
hw/execCtrl.sv
hw/execUnit.sv
sim/clkGen.sv
sim/execUnit_sva.sv
sim/execUnitTb.sv

// File: Makefile
# Verilator build and run for the execute unit testbench
# Variables can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= execUnitTb
FILELIST  ?= execUnit.f
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_TEXT ?= ALL TESTS PASSED
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard hw/*.sv sim/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Pass or fail comes from the log, not the exit status
sim: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/execUnitTb.sv
// Table-driven testbench for the execute unit; top module of the simulation built from execUnit.f
`default_nettype none
`timescale 1ns/1ps

module execUnitTb;

  localparam int resetCycles    = 10;
  // Time budget per table entry, used by the watchdog
  localparam int cyclesPerEntry = 20;

  // One table row, its name lives in a parallel queue
  typedef struct packed {
    aluPkg::instrT            word;
    logic [aluPkg::dataW-1:0] value;
    aluPkg::ccrT              flags;
  } vecT;

  logic          clk;
  logic          arstN;
  logic          instrValid;
  logic          instrReady;
  aluPkg::instrT instr;
  logic          resValid;
  logic          resReady;
  aluPkg::wbT    res;
  aluPkg::ccrT   ccr;

  vecT         vecs[$];
  string       names[$];
  logic        tableLoaded;
  int          errorCount;
  int          checkCount;
  logic [31:0] rngState;

  clkGen u_clk (
    .clk (clk)
  );

  execUnit u_dut (
    .clk        (clk),
    .arstN      (arstN),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .instr      (instr),
    .resValid   (resValid),
    .resReady   (resReady),
    .res        (res),
    .ccr        (ccr)
  );

  bind execUnit execUnitSva u_sva (
    .clk        (clk),
    .arstN      (arstN),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .instr      (instr),
    .resValid   (resValid),
    .resReady   (resReady),
    .res        (res),
    .ccr        (ccr)
  );

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic checkVal(input string testName, input string what,
                          input logic [31:0] expected, input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("error: %s %s expected %h actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic addEntry(input string name, input aluPkg::instrT word,
                          input logic [15:0] value, input aluPkg::ccrT flags);
    vecT v;
    v.word  = word;
    v.value = value;
    v.flags = flags;
    vecs.push_back(v);
    names.push_back(name);
  endtask

  // Word is op, rd, then rs and a zero nibble or an 8-bit imm
  // Flags column is carry, negative, zero
  task automatic loadTable();
    addEntry("ldi r1 0x80",     16'h7180, 16'h0080, 3'b000);
    addEntry("mov r2 r1",       16'h0210, 16'h0080, 3'b000);
    addEntry("ldi r3 0xff",     16'h73FF, 16'h00FF, 3'b000);
    addEntry("shl r3 by 8",     16'h5308, 16'hFF00, 3'b010);
    addEntry("add r3 r1",       16'h1310, 16'hFF80, 3'b010);
    addEntry("add overflow",    16'h1320, 16'h0000, 3'b101);
    addEntry("sub borrow",      16'h2130, 16'hFF80, 3'b110);
    addEntry("ldi r4 0x80",     16'h7480, 16'h0080, 3'b000);
    addEntry("sub to zero",     16'h2240, 16'h0000, 3'b001);
    addEntry("sub no borrow",   16'h2410, 16'hFF00, 3'b010);
    addEntry("ldi r5 0x0f",     16'h750F, 16'h000F, 3'b000);
    addEntry("and to zero",     16'h3540, 16'h0000, 3'b001);
    addEntry("or negative",     16'h4540, 16'hFF00, 3'b010);
    addEntry("ldi r6 0x3c",     16'h763C, 16'h003C, 3'b000);
    addEntry("or r6 r1",        16'h4610, 16'hFFBC, 3'b010);
    addEntry("ldi r7 0x55",     16'h7755, 16'h0055, 3'b000);
    addEntry("and positive",    16'h3760, 16'h0014, 3'b000);
    addEntry("ldi r8 0xc1",     16'h78C1, 16'h00C1, 3'b000);
    addEntry("shl by 0",        16'h5800, 16'h00C1, 3'b000);
    addEntry("shl by 1",        16'h5801, 16'h0182, 3'b000);
    addEntry("shl by 1 carry",  16'h5601, 16'hFF78, 3'b110);
    addEntry("shl by 15",       16'h580F, 16'h0000, 3'b101);
    addEntry("shl by 16",       16'h5610, 16'h0000, 3'b001);
    addEntry("ldi r10 0x81",    16'h7A81, 16'h0081, 3'b000);
    addEntry("shr by 0",        16'h6A00, 16'h0081, 3'b000);
    addEntry("shr by 1",        16'h6A01, 16'h0040, 3'b000);
    addEntry("shr by 15",       16'h610F, 16'h0001, 3'b000);
    addEntry("shr negative",    16'h6400, 16'hFF00, 3'b010);
    // Flags must survive a move
    addEntry("mov keeps flags", 16'h0B30, 16'h0000, 3'b001);
    addEntry("shr by 16",       16'h6410, 16'h0000, 3'b001);
    addEntry("ldi r12 0x01",    16'h7C01, 16'h0001, 3'b000);
    addEntry("ldi r13 0x02",    16'h7D02, 16'h0002, 3'b000);
    addEntry("add r12 r13",     16'h1CD0, 16'h0003, 3'b000);
  endtask

  // Offers each word on a falling edge, holds it until accepted
  task automatic driveInstructions();
    for (int i = 0; i < vecs.size(); i++) begin
      @(negedge clk);
      instrValid = 1'b1;
      instr      = vecs[i].word;
      #1;
      while (!instrReady) begin
        @(negedge clk);
        #1;
      end
      @(posedge clk);
    end
    @(negedge clk);
    instrValid = 1'b0;
    instr      = '0;
  endtask

  // Random back-pressure, record checks, flags a cycle after each transfer
  task automatic collectResults();
    int          idx;
    logic        ccrPending;
    logic        expUpdates;
    aluPkg::ccrT expCcr;
    aluPkg::opT  op;
    idx        = 0;
    ccrPending = 1'b0;
    expCcr     = '0;
    while (idx < vecs.size() || ccrPending) begin
      @(negedge clk);
      rngState = xorshift32(rngState);
      resReady = (rngState[1:0] != 2'b00);
      #1;
      if (ccrPending) begin
        checkVal(names[idx-1], "ccr", 32'(expCcr), 32'(ccr));
        ccrPending = 1'b0;
      end
      if (resValid && resReady) begin
        if (idx >= vecs.size()) begin
          errorCount++;
          $display("an extra writeback record appeared after the last table entry");
        end else begin
          op         = vecs[idx].word.r.op;
          expUpdates = (op != aluPkg::opMov) && (op != aluPkg::opLdi);
          checkVal(names[idx], "rd", 32'(vecs[idx].word.r.rd), 32'(res.rd));
          checkVal(names[idx], "value", 32'(vecs[idx].value), 32'(res.value));
          checkVal(names[idx], "flags", 32'(vecs[idx].flags), 32'(res.flags));
          checkVal(names[idx], "updatesFlags", 32'(expUpdates), 32'(res.updatesFlags));
          if (expUpdates) begin
            expCcr = vecs[idx].flags;
          end
          ccrPending = 1'b1;
          idx++;
        end
      end
    end
  endtask

  initial begin : mainFlow
    arstN       = 1'b1;
    instrValid  = 1'b0;
    instr       = '0;
    resReady    = 1'b0;
    errorCount  = 0;
    checkCount  = 0;
    rngState    = 32'd18888;
    tableLoaded = 1'b0;
    loadTable();
    tableLoaded = 1'b1;
    #10;
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    #1;
    // Idle state right after reset
    checkVal("reset", "resValid", 32'd0, 32'(resValid));
    checkVal("reset", "instrReady", 32'd1, 32'(instrReady));
    checkVal("reset", "ccr", 32'd0, 32'(ccr));
    fork
      driveInstructions();
      collectResults();
    join
    errorCount += u_dut.u_sva.failCount;
    $display("checks %0d, errors %0d, assertion failures %0d",
             checkCount, errorCount, u_dut.u_sva.failCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Ends a stuck run
  initial begin : watchdog
    wait (tableLoaded);
    repeat (resetCycles + vecs.size() * cyclesPerEntry) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles",
             resetCycles + vecs.size() * cyclesPerEntry);
    $display("checks %0d, errors %0d", checkCount, errorCount);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/execUnit_sva.sv
// Bound assertion checker for the execute unit handshakes, hazard stall, flags and reset state
`default_nettype none
`timescale 1ns/1ps

module execUnitSva (
  input wire logic          clk,
  input wire logic          arstN,
  input wire logic          instrValid,
  input wire logic          instrReady,
  input wire aluPkg::instrT instr,
  input wire logic          resValid,
  input wire logic          resReady,
  input wire aluPkg::wbT    res,
  input wire aluPkg::ccrT   ccr
);

  // Assertion failures so far
  int failCount;

  initial failCount = 0;

  // Record and valid hold while the consumer stalls
  resHeld: assert property (@(posedge clk) disable iff (!arstN)
    resValid && !resReady |=> resValid && $stable(res))
    else begin
      failCount++;
      $error("writeback record changed while resReady was low");
    end

  // No issue while the pending record targets the offered rd
  rdHazard: assert property (@(posedge clk) disable iff (!arstN)
    resValid && instrValid && (instr.r.rd == res.rd) |-> !instrReady)
    else begin
      failCount++;
      $error("instruction accepted over a pending record to the same register");
    end

  // Idle pipeline and clear flags under reset
  resetState: assert property (@(posedge clk)
    !arstN |-> !resValid && instrReady && (ccr == '0))
    else begin
      failCount++;
      $error("outputs not in their reset state during reset");
    end

  // Flags only move on an output transfer
  ccrQuiet: assert property (@(posedge clk) disable iff (!arstN)
    !(resValid && resReady) |=> $stable(ccr))
    else begin
      failCount++;
      $error("ccr changed without a writeback transfer");
    end

endmodule

`default_nettype wire

// File: sim/clkGen.sv
// Free-running testbench clock; instantiated once by the execute unit testbench
`default_nettype none
`timescale 1ns/1ps

module clkGen (
  output logic clk
);

  // Half of the 100 ns period
  localparam time halfPeriod = 50ns;

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: hw/execUnit.sv
// Execute unit top; connects controller, register file and ALU datapath to the two handshakes
`default_nettype none
`timescale 1ns/1ps

module execUnit (
  input  wire logic          clk,
  input  wire logic          arstN,
  // Instruction in
  input  wire logic          instrValid,
  output      logic          instrReady,
  input  wire aluPkg::instrT instr,
  // Writeback record out
  output      logic          resValid,
  input  wire logic          resReady,
  output      aluPkg::wbT    res,
  // Current flags
  output      aluPkg::ccrT   ccr
);

  // Read port wiring
  logic [aluPkg::regAddrW-1:0] rdAddrA;
  logic [aluPkg::regAddrW-1:0] rdAddrB;
  logic [aluPkg::dataW-1:0]    rdDataA;
  logic [aluPkg::dataW-1:0]    rdDataB;

  // Controller to datapath
  aluPkg::issueT               issue;
  logic                        s1Load;
  logic                        s2Load;
  logic                        wrEn;

  execCtrl u_ctrl (
    .clk        (clk),
    .arstN      (arstN),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .instr      (instr),
    .resValid   (resValid),
    .resReady   (resReady),
    .res        (res),
    .rdAddrA    (rdAddrA),
    .rdAddrB    (rdAddrB),
    .issue      (issue),
    .s1Load     (s1Load),
    .s2Load     (s2Load),
    .wrEn       (wrEn),
    .ccr        (ccr)
  );

  // Writeback comes straight from the stage-two record
  regFile u_regs (
    .clk     (clk),
    .arstN   (arstN),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .wrEn    (wrEn),
    .wrAddr  (res.rd),
    .wrData  (res.value)
  );

  aluCore u_alu (
    .clk    (clk),
    .arstN  (arstN),
    .s1Load (s1Load),
    .s2Load (s2Load),
    .issue  (issue),
    .opA    (rdDataA),
    .opB    (rdDataB),
    .res    (res)
  );

endmodule

`default_nettype wire

// File: hw/execCtrl.sv
// Execute unit controller; decode, stage occupancy, hazard stall, writeback strobe and flags
`default_nettype none
`timescale 1ns/1ps

module execCtrl (
  input  wire logic                        clk,
  input  wire logic                        arstN,
  // Instruction handshake
  input  wire logic                        instrValid,
  output      logic                        instrReady,
  input  wire aluPkg::instrT               instr,
  // Result handshake
  output      logic                        resValid,
  input  wire logic                        resReady,
  input  wire aluPkg::wbT                  res,
  // Register file read addresses
  output      logic [aluPkg::regAddrW-1:0] rdAddrA,
  output      logic [aluPkg::regAddrW-1:0] rdAddrB,
  // Datapath control
  output      aluPkg::issueT               issue,
  output      logic                        s1Load,
  output      logic                        s2Load,
  output      logic                        wrEn,
  output      aluPkg::ccrT                 ccr
);

  // Stage occupancy and destinations
  logic                        s1Full;
  logic                        s2Full;
  logic [aluPkg::regAddrW-1:0] s1Dest;
  logic [aluPkg::regAddrW-1:0] s2Dest;

  // Decode of the offered word
  aluPkg::opT                  op;
  logic                        usesImm;
  logic                        readsRs;
  logic                        hitS1;
  logic                        hitS2;
  logic                        hazard;
  logic                        outXfer;
  logic                        s1Free;

  // Opcode sits in the same bits in both views
  assign op = instr.r.op;

  // Shifts and ldi take the immediate view
  assign usesImm = (op == aluPkg::opShl) || (op == aluPkg::opShr) || (op == aluPkg::opLdi);

  // Register view ops that read rs
  assign readsRs = (op == aluPkg::opMov) || (op == aluPkg::opAdd) || (op == aluPkg::opSub) ||
                   (op == aluPkg::opAnd) || (op == aluPkg::opOr);

  // rd always checked since it is both a source and the destination
  assign hitS1 = s1Full && ((instr.r.rd == s1Dest) || (readsRs && (instr.r.rs == s1Dest)));
  assign hitS2 = s2Full && ((instr.r.rd == s2Dest) || (readsRs && (instr.r.rs == s2Dest)));
  assign hazard = hitS1 || hitS2;

  // Pipeline advance under back-pressure
  assign outXfer = s2Full && resReady;
  assign s2Load  = s1Full && (!s2Full || resReady);
  assign s1Free  = !s1Full || s2Load;

  assign instrReady = s1Free && !hazard;
  assign s1Load     = instrValid && instrReady;
  assign resValid   = s2Full;

  // Register write lands on the transfer edge
  assign wrEn = outXfer;

  // Operand addresses and issue record
  assign rdAddrA   = instr.r.rd;
  assign rdAddrB   = instr.r.rs;
  assign issue.op  = op;
  assign issue.rd  = instr.i.rd;
  assign issue.imm = usesImm ? instr.i.imm : '0;

  // Stage valid bits and destination tags
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1Full <= 1'b0;
      s2Full <= 1'b0;
      s1Dest <= '0;
      s2Dest <= '0;
    end else begin
      if (s1Load) begin
        s1Full <= 1'b1;
        s1Dest <= instr.r.rd;
      end else if (s2Load) begin
        s1Full <= 1'b0;
      end
      if (s2Load) begin
        s2Full <= 1'b1;
        s2Dest <= s1Dest;
      end else if (outXfer) begin
        s2Full <= 1'b0;
      end
    end
  end

  // Condition code register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ccr <= '0;
    end else if (outXfer && res.updatesFlags) begin
      ccr <= res.flags;
    end
  end

endmodule

`default_nettype wire

// File: hw/aluCore.sv
// Two-stage ALU datapath; captures operands, computes result and flags, holds the writeback record
`default_nettype none
`timescale 1ns/1ps

module aluCore (
  input  wire logic                    clk,
  input  wire logic                    arstN,
  // Stage load enables from the controller
  input  wire logic                    s1Load,
  input  wire logic                    s2Load,
  // Decoded operation and register operands
  input  wire aluPkg::issueT           issue,
  input  wire logic [aluPkg::dataW-1:0] opA,
  input  wire logic [aluPkg::dataW-1:0] opB,
  // Stage-two record
  output      aluPkg::wbT              res
);

  // Stage one contents
  aluPkg::issueT            s1Issue;
  // Value of rd
  logic [aluPkg::dataW-1:0] s1OpA;
  // Value of rs
  logic [aluPkg::dataW-1:0] s1OpB;

  // Raw result, top bit is carry
  logic [aluPkg::dataW:0]   result;
  aluPkg::wbT               wbNext;

  // Stage one capture
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1Issue <= '0;
      s1OpA   <= '0;
      s1OpB   <= '0;
    end else if (s1Load) begin
      s1Issue <= issue;
      s1OpA   <= opA;
      s1OpB   <= opB;
    end
  end

  // Result mux over all operations
  always_comb begin
    result = '0;
    case (s1Issue.op)
      // Plain copy of rs
      aluPkg::opMov: result = {1'b0, s1OpB};
      // Unsigned, carry out at the top
      aluPkg::opAdd: result = {1'b0, s1OpB} + {1'b0, s1OpA};
      // rs minus rd, borrow at the top
      aluPkg::opSub: result = {1'b0, s1OpB} - {1'b0, s1OpA};
      aluPkg::opAnd: result = {1'b0, s1OpB & s1OpA};
      aluPkg::opOr:  result = {1'b0, s1OpB | s1OpA};
      // Last bit out of bit 15 lands in the carry
      aluPkg::opShl: result = {1'b0, s1OpA} << s1Issue.imm;
      // Logical, carry stays clear
      aluPkg::opShr: result = {1'b0, s1OpA >> s1Issue.imm};
      // Zero-extended immediate
      aluPkg::opLdi: result = {{(aluPkg::dataW + 1 - aluPkg::immW){1'b0}}, s1Issue.imm};
      default:       result = '0;
    endcase
  end

  // Flags and record assembly
  always_comb begin
    wbNext.rd             = s1Issue.rd;
    wbNext.value          = result[aluPkg::dataW-1:0];
    wbNext.flags.carry    = result[aluPkg::dataW];
    wbNext.flags.negative = result[aluPkg::dataW-1];
    wbNext.flags.zero     = (result[aluPkg::dataW-1:0] == '0);
    // Moves leave the flags alone
    wbNext.updatesFlags   = (s1Issue.op != aluPkg::opMov) && (s1Issue.op != aluPkg::opLdi);
  end

  // Stage two capture
  // Holds under back-pressure
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      res <= '0;
    end else if (s2Load) begin
      res <= wbNext;
    end
  end

endmodule

`default_nettype wire

// File: hw/regFile.sv
// Sixteen-entry register file with two combinational reads and one clocked write
`default_nettype none
`timescale 1ns/1ps

module regFile (
  input  wire logic                       clk,
  input  wire logic                       arstN,
  // Read port A, rd operand
  input  wire logic [aluPkg::regAddrW-1:0] rdAddrA,
  // Read port B, rs operand
  input  wire logic [aluPkg::regAddrW-1:0] rdAddrB,
  output      logic [aluPkg::dataW-1:0]    rdDataA,
  output      logic [aluPkg::dataW-1:0]    rdDataB,
  // Write port, driven by the result transfer
  input  wire logic                       wrEn,
  input  wire logic [aluPkg::regAddrW-1:0] wrAddr,
  input  wire logic [aluPkg::dataW-1:0]    wrData
);

  // Register storage
  logic [aluPkg::dataW-1:0] regs [aluPkg::regCount];

  // Whole file starts at zero
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < aluPkg::regCount; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Single write per cycle
      if (wrEn) begin
        regs[wrAddr] <= wrData;
      end
    end
  end

  // Reads see the old value during a same-cycle write
  // Hazard stall in the controller keeps that from mattering
  always_comb begin
    rdDataA = regs[rdAddrA];
    rdDataB = regs[rdAddrB];
  end

endmodule

`default_nettype wire

// File: hw/aluPkg.sv
// Shared types and widths for the execute unit; referenced by scoped name from RTL and testbench
`default_nettype none

package aluPkg;

  // Word and field widths fixed by the instruction format
  localparam int dataW    = 16;
  localparam int regAddrW = 4;
  localparam int immW     = 8;
  localparam int regCount = 1 << regAddrW;

  // Opcode in the top nibble of every instruction
  typedef enum logic [3:0] {
    opMov = 4'd0,
    opAdd = 4'd1,
    opSub = 4'd2,
    opAnd = 4'd3,
    opOr  = 4'd4,
    opShl = 4'd5,
    opShr = 4'd6,
    opLdi = 4'd7
  } opT;

  // Register form, two register operands
  typedef struct packed {
    opT                  op;
    logic [regAddrW-1:0] rd;
    logic [regAddrW-1:0] rs;
    logic [3:0]          unused;
  } regFormT;

  // Immediate form, shift amount or load value
  typedef struct packed {
    opT                  op;
    logic [regAddrW-1:0] rd;
    logic [immW-1:0]     imm;
  } immFormT;

  // Same 16-bit word seen either way
  typedef union packed {
    regFormT r;
    immFormT i;
  } instrT;

  // Condition flags, carry at the top
  typedef struct packed {
    logic carry;
    logic negative;
    logic zero;
  } ccrT;

  // Decoded operation handed to the datapath
  typedef struct packed {
    opT                  op;
    logic [regAddrW-1:0] rd;
    logic [immW-1:0]     imm;
  } issueT;

  // Writeback record presented on the result handshake
  typedef struct packed {
    logic [regAddrW-1:0] rd;
    logic [dataW-1:0]    value;
    ccrT                 flags;
    // Clear for mov and ldi
    logic                updatesFlags;
  } wbT;

endpackage

`default_nettype wire
